// File: Makefile
# Verilator build and run for the cpu8 core testbench

VERILATOR ?= verilator
TOP       ?= cpu8_tb
RTL_TOP   ?= cpu8_top
FILELIST  ?= cpu8_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cpu8_top.f
src/cpu8_pkg.sv
src/cpu8_alu.sv
src/cpu8_reg_file.sv
src/cpu8_cmd_arbiter.sv
src/cpu8_exec.sv
src/cpu8_top.sv
dv/cpu8_tb.sv

// File: dv/cpu8_tb.sv
// Uses only registers 0 to 13 of the default REG_COUNT; each port waits for its own handshake
`timescale 1ns/1ps
`default_nettype none

module cpu8_tb;
    import cpu8_pkg::*;

    localparam int CMD_BUDGET = 400;              // Upper bound on commands issued
    localparam int NREGS      = 14;

    logic      clk;
    logic      rst;
    logic      cmd_a_req;
    cpu8_cmd_t cmd_a;
    logic      cmd_a_ack;
    logic      cmd_b_req;
    cpu8_cmd_t cmd_b;
    logic      cmd_b_ack;
    cpu8_rsp_t rsp;

    integer    seed;
    int        mismatch_count;
    int        other_errors;
    int        a_issued;
    int        b_issued;
    int        a_acks;
    int        b_acks;
    logic      contend;                           // Strict alternation expected
    logic      have_prev;
    logic      prev_b;
    logic      ack_q;
    cpu8_rsp_t exp_rsp;
    logic [7:0] model_regs [NREGS];
    logic      model_carry;
    cpu8_cmd_t burst_a [10];
    cpu8_cmd_t burst_b [10];

    cpu8_top #(.REG_COUNT(NREGS)) dut_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_a_req (cmd_a_req),
        .cmd_a     (cmd_a),
        .cmd_a_ack (cmd_a_ack),
        .cmd_b_req (cmd_b_req),
        .cmd_b     (cmd_b),
        .cmd_b_ack (cmd_b_ack),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model, updated in ack order
    task automatic apply_model(input cpu8_cmd_t c);
        int         a;
        int         b;
        int         w;
        logic       wr;
        logic [7:0] d;
        a  = model_regs[c.rb];
        b  = model_regs[c.rc];
        w  = 0;
        wr = 1'b1;
        d  = 8'h00;
        case (4'(c.opcode))
            4'h0: w = a;
            4'h1: w = c.imm;
            4'h2: begin
                wr = 1'b0;
                d  = model_regs[c.ra];
            end
            4'h3: begin
                wr = 1'b0;
                d  = {7'b0, model_carry};
            end
            4'h8: w = 0;
            4'h4: w = (~a) & 255;
            4'h9: w = a & b;
            4'ha: w = a | b;
            4'hd: w = a ^ b;
            4'hb: w = a + b;
            4'hc: w = a - b;
            4'he: w = a + 1;
            4'hf: w = a * b;
            default: wr = 1'b0;                   // NOP slot
        endcase
        // Logic functions clear carry, arithmetic sets it on overflow or borrow
        case (4'(c.opcode))
            4'h4, 4'h9, 4'ha, 4'hd: model_carry = 1'b0;
            4'hb, 4'he, 4'hf: model_carry = (w > 255);
            4'hc: model_carry = (a < b);
            default: ;
        endcase
        if (wr) begin
            model_regs[c.ra] = 8'(w);
            d = 8'(w);
        end
        exp_rsp <= {d, model_carry};
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q       <= 1'b0;
            have_prev   <= 1'b0;
            prev_b      <= 1'b0;
            model_carry = 1'b0;
            for (int i = 0; i < NREGS; i++) begin
                model_regs[i] = 8'h00;
            end
        end else begin
            ack_q <= cmd_a_ack || cmd_b_ack;
            if ((cmd_a_ack || cmd_b_ack) && !ack_q) begin
                apply_model(cmd_a_ack ? cmd_a : cmd_b);
                if (cmd_a_ack) a_acks++;
                else b_acks++;
                if (contend && have_prev) begin
                    assert (prev_b != cmd_b_ack) else begin
                        other_errors++;
                        $display("Arbiter granted the same port twice while both waited");
                    end
                end
                have_prev <= contend;
                prev_b    <= cmd_b_ack;
            end
        end
    end

    // --------------------------------------------------
    // Checks
    rsp_value: assert property (@(posedge clk) disable iff (rst)
        (cmd_a_ack || cmd_b_ack) && ack_q |-> rsp == exp_rsp)
        else begin
            mismatch_count++;
            $display("MISMATCH %0t rsp expected %h actual %h", $time, exp_rsp, $sampled(rsp));
        end

    acks_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(cmd_a_ack && cmd_b_ack))
        else begin
            other_errors++;
            $display("Both port acks were high at %0t", $time);
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        !($rose(cmd_a_ack) && !$past(cmd_a_req)) && !($rose(cmd_b_ack) && !$past(cmd_b_req)))
        else begin
            other_errors++;
            $display("An ack rose without a pending request at %0t", $time);
        end

    hold_a: assert property (@(posedge clk) disable iff (rst)
        cmd_a_ack && cmd_a_req |=> cmd_a_ack && $stable(rsp))
        else begin
            other_errors++;
            $display("Port A lost its ack or response while holding req at %0t", $time);
        end

    hold_b: assert property (@(posedge clk) disable iff (rst)
        cmd_b_ack && cmd_b_req |=> cmd_b_ack && $stable(rsp))
        else begin
            other_errors++;
            $display("Port B lost its ack or response while holding req at %0t", $time);
        end

    // Idle core, ack two cycles after req is sampled
    rise_a: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_a_req) && !cmd_b_req && !cmd_b_ack |-> ##1 !cmd_a_ack ##1 cmd_a_ack)
        else begin
            other_errors++;
            $display("Port A ack latency wrong at %0t", $time);
        end

    fall_a: assert property (@(posedge clk) disable iff (rst)
        $fell(cmd_a_req) |-> ##1 cmd_a_ack ##1 !cmd_a_ack)
        else begin
            other_errors++;
            $display("Port A ack release timing wrong at %0t", $time);
        end

    rise_b: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_b_req) && !cmd_a_req && !cmd_a_ack |-> ##1 !cmd_b_ack ##1 cmd_b_ack)
        else begin
            other_errors++;
            $display("Port B ack latency wrong at %0t", $time);
        end

    fall_b: assert property (@(posedge clk) disable iff (rst)
        $fell(cmd_b_req) |-> ##1 cmd_b_ack ##1 !cmd_b_ack)
        else begin
            other_errors++;
            $display("Port B ack release timing wrong at %0t", $time);
        end

    // --------------------------------------------------
    // Host drivers, called on a falling edge
    task automatic issue_a(input cpu8_cmd_t c, input int hold);
        cmd_a     = c;
        cmd_a_req = 1'b1;
        a_issued++;
        while (!cmd_a_ack) @(negedge clk);
        repeat (hold) @(negedge clk);              // Back-pressure
        cmd_a_req = 1'b0;
        while (cmd_a_ack) @(negedge clk);
    endtask

    task automatic issue_b(input cpu8_cmd_t c, input int hold);
        cmd_b     = c;
        cmd_b_req = 1'b1;
        b_issued++;
        while (!cmd_b_ack) @(negedge clk);
        repeat (hold) @(negedge clk);
        cmd_b_req = 1'b0;
        while (cmd_b_ack) @(negedge clk);
    endtask

    function automatic cpu8_cmd_t make_cmd(input logic [3:0] op, input int ra,
                                           input int rb, input int rc, input logic [7:0] imm);
        cpu8_cmd_t c;
        c.opcode = cpu8_opcode_e'(op);
        c.ra     = 4'(ra);
        c.rb     = 4'(rb);
        c.rc     = 4'(rc);
        c.imm    = imm;
        return c;
    endfunction

    function automatic int rand_reg();
        return int'($unsigned($random(seed)) % NREGS);
    endfunction

    function automatic cpu8_cmd_t rand_alu_cmd();
        int idx;
        idx = int'($unsigned($random(seed)) % 8);
        return make_cmd(idx == 0 ? 4'h4 : 4'(8 + idx), rand_reg(), rand_reg(), rand_reg(),
                        8'h00);
    endfunction

    // --------------------------------------------------
    // Stimulus
    initial begin
        int r;
        seed           = 32'hedb3586f;
        mismatch_count = 0;
        other_errors   = 0;
        a_issued       = 0;
        b_issued       = 0;
        a_acks         = 0;
        b_acks         = 0;
        contend        = 1'b0;
        cmd_a_req      = 1'b0;
        cmd_b_req      = 1'b0;
        cmd_a          = '0;
        cmd_b          = '0;
        rst            = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!cmd_a_ack && !cmd_b_ack && rsp == '0) else begin
            mismatch_count++;
            $display("MISMATCH %0t acks/rsp after reset expected 0 actual %b %b %h",
                     $time, cmd_a_ack, cmd_b_ack, rsp);
        end

        for (int i = 0; i < NREGS; i++) begin      // Registers start at zero
            issue_a(make_cmd(4'h2, i, 0, 0, 8'h00), 0);
        end

        for (int i = 0; i < 16; i++) begin         // Load, store, move, clear
            r = rand_reg();
            issue_a(make_cmd(4'h1, r, 0, 0, 8'($random(seed))), 0);
            issue_b(make_cmd(4'h2, r, 0, 0, 8'h00), 0);
            issue_a(make_cmd(4'h0, rand_reg(), r, 0, 8'h00), 0);
            if (i % 4 == 3) issue_b(make_cmd(4'h8, rand_reg(), 0, 0, 8'h00), 0);
        end

        for (int i = 0; i < 80; i++) begin         // Random ALU with readback
            issue_a(rand_alu_cmd(), 0);
            issue_b(make_cmd(4'h2, cmd_a.ra, 0, 0, 8'h00), 0);
        end

        // Carry rules
        issue_a(make_cmd(4'h1, 0, 0, 0, 8'hff), 0);
        issue_a(make_cmd(4'h1, 1, 0, 0, 8'h01), 0);
        issue_a(make_cmd(4'hb, 2, 0, 1, 8'h00), 0); // ADD overflow
        issue_a(make_cmd(4'h3, 0, 0, 0, 8'h00), 0);
        issue_a(make_cmd(4'h0, 3, 1, 0, 8'h00), 0); // MVR keeps carry
        issue_a(make_cmd(4'h3, 0, 0, 0, 8'h00), 0);
        issue_a(make_cmd(4'h9, 4, 0, 1, 8'h00), 0); // AND clears
        issue_a(make_cmd(4'h3, 0, 0, 0, 8'h00), 0);
        issue_a(make_cmd(4'hc, 5, 1, 0, 8'h00), 0); // SUB borrow
        issue_a(make_cmd(4'h3, 0, 0, 0, 8'h00), 0);
        issue_a(make_cmd(4'h4, 6, 0, 0, 8'h00), 0); // NOT clears
        issue_a(make_cmd(4'he, 7, 0, 0, 8'h00), 0); // INC wrap
        issue_a(make_cmd(4'h6, 0, 0, 0, 8'h00), 0); // NOP keeps carry
        issue_a(make_cmd(4'h3, 0, 0, 0, 8'h00), 0);
        issue_a(make_cmd(4'hf, 8, 0, 0, 8'h00), 0); // MUL high byte
        issue_a(make_cmd(4'h3, 0, 0, 0, 8'h00), 0);

        // Contention with both ports held waiting
        for (int i = 0; i < 10; i++) begin
            burst_a[i] = rand_alu_cmd();
            burst_b[i] = (i % 2 == 0) ? make_cmd(4'h2, rand_reg(), 0, 0, 8'h00)
                                      : rand_alu_cmd();
        end
        contend = 1'b1;
        fork
            for (int i = 0; i < 10; i++) issue_a(burst_a[i], 0);
            for (int i = 0; i < 10; i++) issue_b(burst_b[i], 0);
        join
        contend = 1'b0;
        fork
            issue_a(make_cmd(4'h2, 2, 0, 0, 8'h00), 5);
            issue_b(make_cmd(4'h3, 0, 0, 0, 8'h00), 3);
        join

        repeat (4) @(negedge clk);
        assert (a_acks == a_issued && b_acks == b_issued) else begin
            other_errors++;
            $display("Ack count differs from request count: A %0d/%0d B %0d/%0d",
                     a_acks, a_issued, b_acks, b_issued);
        end
        $display("Summary: %0d mismatches, %0d other errors", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // --------------------------------------------------
    // Watchdog
    initial begin
        #(CMD_BUDGET * 20 * 20 + 2000);
        $display("Timeout: the run did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/cpu8_alu.sv
// Purely combinational; op must always be a known value, carry rules follow the ALU function
`timescale 1ns/1ps
`default_nettype none

module cpu8_alu (
    input  logic [cpu8_pkg::cpu8_data_w-1:0] a,
    input  logic [cpu8_pkg::cpu8_data_w-1:0] b,
    input  cpu8_pkg::cpu8_alu_op_e           op,
    output logic [cpu8_pkg::cpu8_data_w-1:0] result,
    output logic                             carry
);
    import cpu8_pkg::*;

    logic [cpu8_data_w:0]     sum;            // Extra bit for carry out
    logic [2*cpu8_data_w-1:0] product;        // Full product

    assign sum     = {1'b0, a} + {1'b0, b};
    assign product = {{cpu8_data_w{1'b0}}, a} * {{cpu8_data_w{1'b0}}, b};

    always_comb begin
        result = '0;
        carry  = 1'b0;                        // Logic functions clear it
        case (op)
            ALU_NOT: result = ~a;
            ALU_AND: result = a & b;
            ALU_ORA: result = a | b;
            ALU_ADD: begin
                result = sum[cpu8_data_w-1:0];
                carry  = sum[cpu8_data_w];
            end
            ALU_SUB: begin
                result = a - b;
                carry  = (a < b);             // Borrow
            end
            ALU_XOR: result = a ^ b;
            ALU_INC: begin
                result = a + cpu8_data_w'(1);
                carry  = a[cpu8_data_w-1] & ~result[cpu8_data_w-1];  // Wrap past 8'hff
            end
            ALU_MUL: begin
                result = product[cpu8_data_w-1:0];
                carry  = |product[2*cpu8_data_w-1:cpu8_data_w];     // High byte lost
            end
            default: begin
                result = '0;
                carry  = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------
    // Checks
    // The decoder supplies a fixed op even for non-ALU instructions
    always_comb begin
        assert (!$isunknown(op))
            else $error("cpu8_alu: op is unknown");
    end

endmodule

`default_nettype wire

// File: src/cpu8_cmd_arbiter.sv
// Hosts must hold cmd stable while req is high and re-raise req only after seeing ack low
`timescale 1ns/1ps
`default_nettype none

module cpu8_cmd_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                a_req,
    input  cpu8_pkg::cpu8_cmd_t a_cmd,
    output logic                a_ack,
    input  logic                b_req,
    input  cpu8_pkg::cpu8_cmd_t b_cmd,
    output logic                b_ack,
    output logic                exec_req,
    output cpu8_pkg::cpu8_cmd_t exec_cmd,
    input  logic                exec_ack
);

    typedef enum logic [1:0] {
        IDLE,
        GRANT_A,
        GRANT_B,
        RELEASE                               // Waiting for exec_ack to drop
    } arb_state_e;

    arb_state_e state;
    logic       last_b;                       // B served last, also the live grant
    logic       free;                         // Core can take a command now
    logic       pick_a;
    logic       pick_b;
    logic       granted_req;

    // ------------------------------------------------
    // Round-robin choice
    assign free        = (state == IDLE) || (state == RELEASE && !exec_ack);
    assign pick_a      = a_req && (!b_req || last_b);
    assign pick_b      = b_req && (!a_req || !last_b);
    assign granted_req = last_b ? b_req : a_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            last_b   <= 1'b1;                 // A wins the first tie
            exec_req <= 1'b0;
        end else begin
            case (state)
                GRANT_A, GRANT_B: begin
                    if (exec_ack && !granted_req) begin  // Host released
                        exec_req <= 1'b0;
                        state    <= RELEASE;
                    end
                end
                default: begin                // IDLE and RELEASE
                    if (free && pick_a) begin
                        state    <= GRANT_A;
                        last_b   <= 1'b0;
                        exec_req <= 1'b1;
                    end else if (free && pick_b) begin
                        state    <= GRANT_B;
                        last_b   <= 1'b1;
                        exec_req <= 1'b1;
                    end else if (free) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (free && pick_a) begin
            exec_cmd <= a_cmd;
        end else if (free && pick_b) begin
            exec_cmd <= b_cmd;
        end
    end

    // Only the granted port sees the ack
    assign a_ack = exec_ack && !last_b;
    assign b_ack = exec_ack && last_b;

    // ------------------------------------------------
    // Checks
    a_ack_owner: assert property (@(posedge clk) disable iff (rst)
        $rose(exec_ack) |-> (last_b ? $past(b_req) : $past(a_req)))
        else $error("cpu8_cmd_arbiter: ack routed to a port with no request");

    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        exec_ack |=> $stable(last_b) && $stable(exec_cmd))
        else $error("cpu8_cmd_arbiter: grant moved while exec_ack was high");

endmodule

`default_nettype wire

// File: src/cpu8_exec.sv
// One instruction per req/ack cycle; cmd must stay stable until ack, unused opcodes are NOPs
`timescale 1ns/1ps
`default_nettype none

module cpu8_exec (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req,
    input  cpu8_pkg::cpu8_cmd_t              cmd,
    output logic                             ack,
    output cpu8_pkg::cpu8_rsp_t              rsp,
    output logic                             rf_we,
    output logic [3:0]                       rf_waddr,
    output logic [cpu8_pkg::cpu8_data_w-1:0] rf_wdata,
    output logic [3:0]                       rf_raddr_0,
    output logic [3:0]                       rf_raddr_1,
    output logic [3:0]                       rf_raddr_2,
    input  logic [cpu8_pkg::cpu8_data_w-1:0] rf_rdata_0,
    input  logic [cpu8_pkg::cpu8_data_w-1:0] rf_rdata_1,
    input  logic [cpu8_pkg::cpu8_data_w-1:0] rf_rdata_2,
    output logic [cpu8_pkg::cpu8_data_w-1:0] alu_a,
    output logic [cpu8_pkg::cpu8_data_w-1:0] alu_b,
    output cpu8_pkg::cpu8_alu_op_e           alu_op,
    input  logic [cpu8_pkg::cpu8_data_w-1:0] alu_result,
    input  logic                             alu_carry
);
    import cpu8_pkg::*;

    typedef enum logic {
        EX_IDLE,
        EX_DONE                               // Ack high, waiting for req low
    } exec_state_e;

    exec_state_e            state;
    logic                   status;           // Carry flag
    logic                   start;            // Command executes this cycle
    logic                   dec_we;
    logic                   dec_alu;          // ALU instruction, updates carry
    logic [cpu8_data_w-1:0] dec_wdata;
    logic [cpu8_data_w-1:0] dec_rsp;

    // ------------------------------------------------
    // Operand routing: ra written or read by STB, rb and rc are sources
    assign rf_raddr_0 = cmd.rb;
    assign rf_raddr_1 = cmd.rc;
    assign rf_raddr_2 = cmd.ra;
    assign rf_waddr   = cmd.ra;
    assign alu_a      = rf_rdata_0;
    assign alu_b      = rf_rdata_1;

    // ALU function, kept apart from the data mux that reads its result
    always_comb begin
        dec_alu = 1'b1;
        alu_op  = ALU_NOT;                    // Known value for non-ALU ops
        case (cmd.opcode)
            OP_NOT: alu_op = ALU_NOT;
            OP_AND, OP_ORA, OP_ADD, OP_SUB, OP_XOR, OP_INC, OP_MUL:
                alu_op = cpu8_alu_op_e'(cmd.opcode[2:0]);
            default: dec_alu = 1'b0;
        endcase
    end

    always_comb begin
        dec_we    = 1'b0;
        dec_wdata = '0;
        dec_rsp   = '0;
        case (cmd.opcode)
            OP_MVR: begin
                dec_we    = 1'b1;
                dec_wdata = rf_rdata_0;
            end
            OP_LDB: begin
                dec_we    = 1'b1;
                dec_wdata = cmd.imm;
            end
            OP_CLR: dec_we = 1'b1;            // Writes zero
            OP_STB: dec_rsp = rf_rdata_2;
            OP_RDS: dec_rsp = {{(cpu8_data_w-1){1'b0}}, status};
            default: begin
                if (dec_alu) begin
                    dec_we    = 1'b1;
                    dec_wdata = alu_result;
                end
            end
        endcase
        if (dec_we) begin
            dec_rsp = dec_wdata;              // Echo the written value
        end
    end

    // ------------------------------------------------
    // Sequencer
    assign start    = (state == EX_IDLE) && req;
    assign ack      = (state == EX_DONE);
    assign rf_we    = start && dec_we;
    assign rf_wdata = dec_wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= EX_IDLE;
            status <= 1'b0;
            rsp    <= '0;
        end else begin
            if (start) begin
                state     <= EX_DONE;
                rsp.data  <= dec_rsp;
                rsp.carry <= dec_alu ? alu_carry : status;
                if (dec_alu) begin
                    status <= alu_carry;
                end
            end else if (ack && !req) begin
                state <= EX_IDLE;
            end
        end
    end

    // ------------------------------------------------
    // Checks
    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        (req && !ack) |=> $stable(cmd))
        else $error("cpu8_exec: cmd changed before ack");

endmodule

`default_nettype wire

// File: src/cpu8_pkg.sv
// Byte-wide datapath is fixed; opcode encodings and the one-bit status assume 8-bit data
`default_nettype none

package cpu8_pkg;

    // ------------------------------------------------
    // Datapath width
    localparam int cpu8_data_w = 8;           // Byte machine

    // ------------------------------------------------
    // ALU functions
    typedef enum logic [2:0] {
        ALU_NOT = 3'd0,
        ALU_AND = 3'd1,
        ALU_ORA = 3'd2,
        ALU_ADD = 3'd3,
        ALU_SUB = 3'd4,                       // Carry is borrow
        ALU_XOR = 3'd5,
        ALU_INC = 3'd6,
        ALU_MUL = 3'd7                        // Low byte kept
    } cpu8_alu_op_e;

    // Instruction set. ALU instructions carry bit 3 set plus the ALU function,
    // except NOT, whose slot 4'h8 decodes as CLR; NOT sits in free slot 4'h4
    typedef enum logic [3:0] {
        OP_MVR = 4'h0,                        // ra <= rb
        OP_LDB = 4'h1,                        // ra <= imm
        OP_STB = 4'h2,                        // Return ra
        OP_RDS = 4'h3,                        // Return status
        OP_NOT = 4'h4,
        OP_CLR = 4'h8,                        // ra <= 0
        OP_AND = 4'h9,
        OP_ORA = 4'ha,
        OP_ADD = 4'hb,
        OP_SUB = 4'hc,
        OP_XOR = 4'hd,
        OP_INC = 4'he,
        OP_MUL = 4'hf
    } cpu8_opcode_e;

    typedef struct packed {
        cpu8_opcode_e           opcode;
        logic [3:0]             ra;           // Destination, STB source
        logic [3:0]             rb;           // First source
        logic [3:0]             rc;           // Second source
        logic [cpu8_data_w-1:0] imm;          // LDB data
    } cpu8_cmd_t;

    typedef struct packed {
        logic [cpu8_data_w-1:0] data;
        logic                   carry;        // Status after the instruction
    } cpu8_rsp_t;

endpackage

`default_nettype wire

// File: src/cpu8_reg_file.sv
// REG_COUNT must be 1 to 16; writes past REG_COUNT are dropped and such reads return zero
`timescale 1ns/1ps
`default_nettype none

module cpu8_reg_file #(
    parameter int REG_COUNT = 14
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             we,
    input  logic [3:0]                       waddr,
    input  logic [cpu8_pkg::cpu8_data_w-1:0] wdata,
    input  logic [3:0]                       raddr_0,
    input  logic [3:0]                       raddr_1,
    input  logic [3:0]                       raddr_2,
    output logic [cpu8_pkg::cpu8_data_w-1:0] rdata_0,
    output logic [cpu8_pkg::cpu8_data_w-1:0] rdata_1,
    output logic [cpu8_pkg::cpu8_data_w-1:0] rdata_2
);
    import cpu8_pkg::*;

    logic [cpu8_data_w-1:0] mem [REG_COUNT];

    function automatic logic in_range(input logic [3:0] addr);
        return int'(addr) < REG_COUNT;
    endfunction

    // ------------------------------------------------
    // Write port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else if (we && in_range(waddr)) begin
            mem[waddr] <= wdata;
        end
    end

    // Read ports, out-of-range reads as zero
    assign rdata_0 = in_range(raddr_0) ? mem[raddr_0] : '0;
    assign rdata_1 = in_range(raddr_1) ? mem[raddr_1] : '0;
    assign rdata_2 = in_range(raddr_2) ? mem[raddr_2] : '0;

    // ------------------------------------------------
    // Checks
    a_waddr_range: assert property (@(posedge clk) disable iff (rst)
        we |-> in_range(waddr))
        else $error("cpu8_reg_file: write to register %0d dropped, only %0d exist",
                    waddr, REG_COUNT);

endmodule

`default_nettype wire

// File: src/cpu8_top.sv
// Two four-phase command ports share one core; rsp is valid only while either ack is high
`timescale 1ns/1ps
`default_nettype none

module cpu8_top #(
    parameter int REG_COUNT = 14              // At most 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_a_req,
    input  cpu8_pkg::cpu8_cmd_t cmd_a,
    output logic                cmd_a_ack,
    input  logic                cmd_b_req,
    input  cpu8_pkg::cpu8_cmd_t cmd_b,
    output logic                cmd_b_ack,
    output cpu8_pkg::cpu8_rsp_t rsp
);
    import cpu8_pkg::*;

    logic                   exec_req;
    cpu8_cmd_t              exec_cmd;
    logic                   exec_ack;
    logic                   rf_we;
    logic [3:0]             rf_waddr;
    logic [cpu8_data_w-1:0] rf_wdata;
    logic [3:0]             rf_raddr_0;
    logic [3:0]             rf_raddr_1;
    logic [3:0]             rf_raddr_2;
    logic [cpu8_data_w-1:0] rf_rdata_0;
    logic [cpu8_data_w-1:0] rf_rdata_1;
    logic [cpu8_data_w-1:0] rf_rdata_2;
    logic [cpu8_data_w-1:0] alu_a;
    logic [cpu8_data_w-1:0] alu_b;
    cpu8_alu_op_e           alu_op;
    logic [cpu8_data_w-1:0] alu_result;
    logic                   alu_carry;

    cpu8_cmd_arbiter arb_i (
        .clk      (clk),
        .rst      (rst),
        .a_req    (cmd_a_req),
        .a_cmd    (cmd_a),
        .a_ack    (cmd_a_ack),
        .b_req    (cmd_b_req),
        .b_cmd    (cmd_b),
        .b_ack    (cmd_b_ack),
        .exec_req (exec_req),
        .exec_cmd (exec_cmd),
        .exec_ack (exec_ack)
    );

    cpu8_exec exec_i (
        .clk        (clk),
        .rst        (rst),
        .req        (exec_req),
        .cmd        (exec_cmd),
        .ack        (exec_ack),
        .rsp        (rsp),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .rf_raddr_0 (rf_raddr_0),
        .rf_raddr_1 (rf_raddr_1),
        .rf_raddr_2 (rf_raddr_2),
        .rf_rdata_0 (rf_rdata_0),
        .rf_rdata_1 (rf_rdata_1),
        .rf_rdata_2 (rf_rdata_2),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .alu_carry  (alu_carry)
    );

    cpu8_reg_file #(
        .REG_COUNT (REG_COUNT)
    ) rf_i (
        .clk     (clk),
        .rst     (rst),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .raddr_0 (rf_raddr_0),
        .raddr_1 (rf_raddr_1),
        .raddr_2 (rf_raddr_2),
        .rdata_0 (rf_rdata_0),
        .rdata_1 (rf_rdata_1),
        .rdata_2 (rf_rdata_2)
    );

    cpu8_alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .carry  (alu_carry)
    );

endmodule

`default_nettype wire
